// File: csr_serial_top.f
src/csr_pkg.sv
src/csr_bit_counter.sv
src/csr_status_bits.sv
src/csr_scratch_ram.sv
src/csr_sequencer.sv
src/csr_serial_top.sv
test/csr_serial_sva.sv
test/csr_serial_tb.sv

// File: Bender.yml
package:
  name: csr_serial

sources:
  - src/csr_pkg.sv
  - src/csr_bit_counter.sv
  - src/csr_status_bits.sv
  - src/csr_scratch_ram.sv
  - src/csr_sequencer.sv
  - src/csr_serial_top.sv
  - target: test
    files:
      - test/csr_serial_sva.sv
      - test/csr_serial_tb.sv

// File: test/csr_serial_tb.sv
`timescale 1ns/10ps

module csr_serial_tb;
   import csr_pkg::*;

   localparam int CMD_DEPTH = 2;
   // 36 csr accesses, 30 for traps, 4 for mret, 2 held back, 3 for the timer
   localparam int NUM_CMDS        = 75;
   localparam int WATCHDOG_CYCLES = NUM_CMDS * 40 + 1000;

   logic     i_clk = 1'b0;
   logic     i_reset;
   logic     i_cmd_valid;
   csr_cmd_t i_cmd;
   logic     o_cmd_credit;
   logic     o_rsp_valid;
   csr_rsp_t o_rsp;
   logic     i_rsp_credit = 1'b0;
   logic     i_mtip;
   logic     o_new_irq;

   integer    seed       = 13;
   logic      grant_on   = 1'b1;
   int        issued     = 0;
   int        returned   = 0;
   int        granted    = 0;
   int        received   = 0;
   int        irq_pulses = 0;
   int        mismatches = 0;
   int        other_errs = 0;
   csr_data_t exp_q[$];
   csr_data_t exp_word;

   // shadow csr state
   logic      m_mie      = 1'b0;
   logic      m_mpie     = 1'b0;
   logic      m_mtie     = 1'b0;
   csr_data_t m_mcause   = '0;
   csr_data_t m_mscratch = '0;
   csr_data_t m_mtvec    = '0;
   csr_data_t m_mepc     = '0;

   csr_serial_top #(
      .CMD_DEPTH (CMD_DEPTH)
   ) u_csr_serial_top (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_cmd_valid  (i_cmd_valid),
      .i_cmd        (i_cmd),
      .o_cmd_credit (o_cmd_credit),
      .o_rsp_valid  (o_rsp_valid),
      .o_rsp        (o_rsp),
      .i_rsp_credit (i_rsp_credit),
      .i_mtip       (i_mtip),
      .o_new_irq    (o_new_irq)
   );

   always #10 i_clk = ~i_clk;

   function automatic csr_data_t combine_bits(csr_data_t old, csr_data_t d, csr_src_t src);
      case (src)
         SRC_EXT: return d;
         SRC_SET: return old | d;
         SRC_CLR: return old & ~d;
         default: return old;
      endcase
   endfunction

   // updates the shadow state and returns the expected response word
   function automatic csr_data_t apply_model(csr_cmd_t cmd);
      csr_data_t old;
      csr_data_t nw;
      old = '0;
      if (cmd.kind == KIND_TRAP) begin
         old    = m_mtvec;
         m_mepc = cmd.data;
         m_mpie = m_mie;
         m_mie  = 1'b0;
         case (cmd.trap)
            TRAP_IRQ:    m_mcause = 32'h8000_0007;
            TRAP_ECALL:  m_mcause = 32'd11;
            TRAP_EBREAK: m_mcause = 32'd3;
            default:     m_mcause = cmd.store ? 32'd6 : 32'd4;
         endcase
      end else if (cmd.kind == KIND_MRET) begin
         old   = m_mepc;
         m_mie = m_mpie;
      end else begin
         // mpie reads as zero so it is written back from zero
         case (cmd.sel)
            SEL_MSTATUS:  old = {28'd0, m_mie, 3'd0};
            SEL_MIE:      old = {24'd0, m_mtie, 7'd0};
            SEL_MCAUSE:   old = m_mcause;
            SEL_MSCRATCH: old = m_mscratch;
            SEL_MTVEC:    old = m_mtvec;
            SEL_MEPC:     old = m_mepc;
            default:      old = '0;
         endcase
         nw = combine_bits(old, cmd.data, cmd.src);
         case (cmd.sel)
            SEL_MSTATUS: begin
               m_mie  = nw[3];
               m_mpie = nw[7];
            end
            SEL_MIE:      m_mtie = nw[7];
            SEL_MCAUSE:   m_mcause = nw & 32'h8000_000f;
            SEL_MSCRATCH: m_mscratch = nw;
            SEL_MTVEC:    m_mtvec = nw;
            SEL_MEPC:     m_mepc = nw;
            default: begin
            end
         endcase
      end
      return old;
   endfunction

   function automatic csr_cmd_t csr_access(csr_sel_t sel, csr_src_t src, csr_data_t data);
      return '{kind: KIND_CSR, sel: sel, src: src, trap: TRAP_IRQ, store: 1'b0, data: data};
   endfunction

   function automatic csr_cmd_t flow_cmd(cmd_kind_t kind, trap_kind_t trap, logic store,
                                         csr_data_t data);
      return '{kind: kind, sel: SEL_MSTATUS, src: SRC_CSR, trap: trap, store: store, data: data};
   endfunction

   task automatic send_cmd(input csr_cmd_t cmd);
      while (issued - returned >= CMD_DEPTH) @(posedge i_clk);
      exp_q.push_back(apply_model(cmd));
      i_cmd_valid <= 1'b1;
      i_cmd       <= cmd;
      issued      <= issued + 1;
      @(posedge i_clk);
      i_cmd_valid <= 1'b0;
   endtask

   task automatic wait_drained();
      while (received != issued) @(posedge i_clk);
   endtask

   task automatic pulse_mtip(input int expected);
      int base;
      base = irq_pulses;
      i_mtip <= 1'b1;
      repeat (10) @(posedge i_clk);
      assert (irq_pulses - base == expected) else begin
         $display("Mismatch at %0t: o_new_irq pulses expected %0d got %0d",
                  $time, expected, irq_pulses - base);
         mismatches++;
      end
      i_mtip <= 1'b0;
      repeat (4) @(posedge i_clk);
   endtask

   // response slots granted at random for commands already issued
   always @(posedge i_clk) begin
      if (i_reset) begin
         i_rsp_credit <= 1'b0;
      end else if (grant_on && granted < issued && ($random(seed) & 1)) begin
         i_rsp_credit <= 1'b1;
         granted      <= granted + 1;
      end else begin
         i_rsp_credit <= 1'b0;
      end
   end

   always @(posedge i_clk) begin
      if (!i_reset && o_cmd_credit) begin
         returned <= returned + 1;
      end
      if (!i_reset && o_new_irq) begin
         irq_pulses <= irq_pulses + 1;
      end
   end

   always @(posedge i_clk) begin
      if (!i_reset && o_rsp_valid) begin
         assert (exp_q.size() > 0) else begin
            $display("response at %0t with no command waiting for it", $time);
            other_errs++;
         end
         if (exp_q.size() > 0) begin
            exp_word = exp_q.pop_front();
            assert (o_rsp.data == exp_word) else begin
               $display("Mismatch at %0t: o_rsp expected %08h got %08h",
                        $time, exp_word, o_rsp.data);
               mismatches++;
            end
         end
         received <= received + 1;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge i_clk);
      $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("tests failed");
      $finish;
   end

   initial begin : main
      int s;
      int base;
      int sva_fails;
      i_reset     = 1'b1;
      i_cmd_valid = 1'b0;
      i_cmd       = '0;
      i_mtip      = 1'b0;
      repeat (5) @(posedge i_clk);
      i_reset <= 1'b0;
      @(posedge i_clk);

      // write, set and clear on every csr, each read back
      for (s = 0; s < 6; s++) begin
         send_cmd(csr_access(csr_sel_t'(s), SRC_EXT, $random(seed)));
         send_cmd(csr_access(csr_sel_t'(s), SRC_CSR, $random(seed)));
         send_cmd(csr_access(csr_sel_t'(s), SRC_SET, $random(seed)));
         send_cmd(csr_access(csr_sel_t'(s), SRC_CSR, $random(seed)));
         send_cmd(csr_access(csr_sel_t'(s), SRC_CLR, $random(seed)));
         send_cmd(csr_access(csr_sel_t'(s), SRC_CSR, $random(seed)));
      end

      // irq, ecall, ebreak, misaligned load and store
      for (s = 0; s < 5; s++) begin
         send_cmd(csr_access(SEL_MSTATUS, SRC_SET, 32'h8));
         send_cmd(csr_access(SEL_MTVEC, SRC_EXT, $random(seed)));
         send_cmd(flow_cmd(KIND_TRAP, trap_kind_t'((s > 3) ? 3 : s), s == 4, $random(seed)));
         send_cmd(csr_access(SEL_MCAUSE, SRC_CSR, '0));
         send_cmd(csr_access(SEL_MEPC, SRC_CSR, '0));
         send_cmd(csr_access(SEL_MSTATUS, SRC_CSR, '0));
      end

      send_cmd(csr_access(SEL_MSTATUS, SRC_SET, 32'h8));
      send_cmd(flow_cmd(KIND_TRAP, TRAP_ECALL, 1'b0, $random(seed)));
      send_cmd(flow_cmd(KIND_MRET, TRAP_IRQ, 1'b0, '0));
      send_cmd(csr_access(SEL_MSTATUS, SRC_CSR, '0));

      // back-pressure with every response credit held back
      wait_drained();
      grant_on <= 1'b0;
      send_cmd(csr_access(SEL_MSCRATCH, SRC_EXT, $random(seed)));
      send_cmd(csr_access(SEL_MSCRATCH, SRC_CSR, '0));
      base = received;
      repeat (100) @(posedge i_clk);
      assert (received == base) else begin
         $display("a response arrived while no response credit was granted");
         other_errs++;
      end
      grant_on <= 1'b1;
      wait_drained();

      send_cmd(csr_access(SEL_MSTATUS, SRC_SET, 32'h8));
      send_cmd(csr_access(SEL_MIE, SRC_SET, 32'h80));
      wait_drained();
      pulse_mtip((m_mie && m_mtie) ? 1 : 0);
      send_cmd(csr_access(SEL_MSTATUS, SRC_CLR, 32'h8));
      wait_drained();
      pulse_mtip((m_mie && m_mtie) ? 1 : 0);

      wait_drained();
      repeat (2) @(posedge i_clk);
      sva_fails = u_csr_serial_top.u_sva.fail_count;
      $display("errors: %0d mismatches, %0d other, %0d assertion failures",
               mismatches, other_errs, sva_fails);
      if (mismatches + other_errs + sva_fails == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: test/csr_serial_sva.sv
`timescale 1ns/10ps

module csr_serial_sva #(
   parameter int CMD_DEPTH = 2
) (
   input logic              i_clk,
   input logic              i_reset,
   input logic              i_cmd_valid,
   input logic              i_cmd_credit,
   input logic              i_rsp_credit,
   input logic              i_rsp_valid,
   input logic              i_new_irq,
   input csr_pkg::csr_cnt_t i_cnt
);

   int rsp_cred;
   int cmd_out;
   int fail_count = 0;

   // host side view of both credit loops
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rsp_cred <= 0;
         cmd_out  <= 0;
      end else begin
         rsp_cred <= rsp_cred + int'(i_rsp_credit) - int'(i_rsp_valid);
         cmd_out  <= cmd_out + int'(i_cmd_valid) - int'(i_cmd_credit);
      end
   end

   a_rsp_credit: assert property (@(posedge i_clk) disable iff (i_reset)
      i_rsp_valid |-> rsp_cred > 0)
      else begin
         $error("response sent while no response credit was held");
         fail_count++;
      end

   a_done_rsp: assert property (@(posedge i_clk) disable iff (i_reset)
      i_cnt.done |=> i_rsp_valid)
      else begin
         $error("response did not follow the end of the pass by one cycle");
         fail_count++;
      end

   // a credit with no command behind it drives the count below zero
   a_cmd_depth: assert property (@(posedge i_clk) disable iff (i_reset)
      cmd_out >= 0 && cmd_out <= CMD_DEPTH)
      else begin
         $error("outstanding command count left the range from zero to the queue depth");
         fail_count++;
      end

   a_irq_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
      i_new_irq |=> !i_new_irq)
      else begin
         $error("new interrupt strobe held for two cycles");
         fail_count++;
      end

endmodule

bind csr_serial_top csr_serial_sva #(
   .CMD_DEPTH (CMD_DEPTH)
) u_sva (
   .i_clk        (i_clk),
   .i_reset      (i_reset),
   .i_cmd_valid  (i_cmd_valid),
   .i_cmd_credit (o_cmd_credit),
   .i_rsp_credit (i_rsp_credit),
   .i_rsp_valid  (o_rsp_valid),
   .i_new_irq    (o_new_irq),
   .i_cnt        (cnt)
);

// File: src/csr_serial_top.sv
`timescale 1ns/10ps

module csr_serial_top #(
   parameter int CMD_DEPTH = 2
) (
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_cmd_valid,
   input  csr_pkg::csr_cmd_t i_cmd,
   output logic              o_cmd_credit,
   output logic              o_rsp_valid,
   output csr_pkg::csr_rsp_t o_rsp,
   input  logic              i_rsp_credit,
   input  logic              i_mtip,
   output logic              o_new_irq
);
   import csr_pkg::*;

   csr_cnt_t  cnt;
   csr_ctrl_t ctrl;
   logic      pass_en;
   logic      ser_d;
   logic      status_q;
   logic      ram_q;
   logic      csr_in;
   logic      ser_q;

   // serial result from both storage blocks
   assign ser_q = status_q | ram_q;

   csr_sequencer #(
      .CMD_DEPTH (CMD_DEPTH)
   ) u_sequencer (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_cmd_valid  (i_cmd_valid),
      .i_cmd        (i_cmd),
      .o_cmd_credit (o_cmd_credit),
      .i_rsp_credit (i_rsp_credit),
      .o_rsp_valid  (o_rsp_valid),
      .o_rsp        (o_rsp),
      .i_cnt        (cnt),
      .i_q          (ser_q),
      .o_en         (pass_en),
      .o_d          (ser_d),
      .o_ctrl       (ctrl)
   );

   csr_bit_counter u_bit_counter (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_en    (pass_en),
      .o_cnt   (cnt)
   );

   csr_status_bits u_status_bits (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_cnt     (cnt),
      .i_ctrl    (ctrl),
      .i_mtip    (i_mtip),
      .i_d       (ser_d),
      .i_ram_q   (ram_q),
      .o_csr_in  (csr_in),
      .o_q       (status_q),
      .o_new_irq (o_new_irq)
   );

   csr_scratch_ram u_scratch_ram (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_cnt    (cnt),
      .i_ctrl   (ctrl),
      .i_d      (ser_d),
      .i_csr_in (csr_in),
      .o_q      (ram_q)
   );

endmodule

// File: src/csr_sequencer.sv
`timescale 1ns/10ps

module csr_sequencer #(
   parameter int CMD_DEPTH = 2
) (
   input  logic               i_clk,
   input  logic               i_reset,
   input  logic               i_cmd_valid,
   input  csr_pkg::csr_cmd_t  i_cmd,
   output logic               o_cmd_credit,
   input  logic               i_rsp_credit,
   output logic               o_rsp_valid,
   output csr_pkg::csr_rsp_t  o_rsp,
   input  csr_pkg::csr_cnt_t  i_cnt,
   input  logic               i_q,
   output logic               o_en,
   output logic               o_d,
   output csr_pkg::csr_ctrl_t o_ctrl
);
   import csr_pkg::*;

   localparam int PTR_W  = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
   localparam int CNT_W  = $clog2(CMD_DEPTH + 1);
   localparam int CRED_W = 8;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      RESP
   } sequencer_state_e;

   sequencer_state_e  state;
   csr_cmd_t          fifo_mem [CMD_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  fifo_cnt;
   logic [CRED_W-1:0] rsp_cred;
   csr_cmd_t          cur_cmd;
   csr_data_t         opnd;
   csr_data_t         result;
   logic              pop;
   logic              cmd_credit_q;

   // start only with a command waiting and a slot at the host
   assign pop = (state == IDLE) && (fifo_cnt != '0) && (rsp_cred != '0);

   assign o_en         = (state == RUN);
   assign o_d          = opnd[0];
   assign o_rsp_valid  = (state == RESP);
   assign o_rsp.data   = result;
   assign o_cmd_credit = cmd_credit_q;

   always_ff @(posedge i_clk) begin
      if (i_cmd_valid) begin
         fifo_mem[wr_ptr] <= i_cmd;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         fifo_cnt     <= '0;
         rsp_cred     <= '0;
         cmd_credit_q <= 1'b0;
      end else begin
         if (i_cmd_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         fifo_cnt     <= fifo_cnt + CNT_W'(i_cmd_valid) - CNT_W'(pop);
         rsp_cred     <= rsp_cred + CRED_W'(i_rsp_credit) - CRED_W'(o_rsp_valid);
         cmd_credit_q <= pop;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: if (pop) state <= RUN;
            RUN:  if (i_cnt.done) state <= RESP;
            default: state <= IDLE;
         endcase
      end
   end

   // operand out and result in, lsb first
   always_ff @(posedge i_clk) begin
      if (pop) begin
         cur_cmd <= fifo_mem[rd_ptr];
         opnd    <= fifo_mem[rd_ptr].data;
      end else if (o_en) begin
         opnd   <= opnd >> 1;
         result <= {i_q, result[CSR_W-1:1]};
      end
   end

   always_comb begin
      o_ctrl = '0;
      if (state == RUN) begin
         case (cur_cmd.kind)
            KIND_CSR: begin
               o_ctrl.mstatus_en = (cur_cmd.sel == SEL_MSTATUS);
               o_ctrl.mie_en     = (cur_cmd.sel == SEL_MIE);
               o_ctrl.mcause_en  = (cur_cmd.sel == SEL_MCAUSE);
               o_ctrl.ram_sel    = cur_cmd.sel;
               o_ctrl.src        = cur_cmd.src;
            end
            KIND_TRAP: begin
               o_ctrl.trap_taken  = 1'b1;
               o_ctrl.ram_sel     = SEL_MTVEC;
               o_ctrl.pending_irq = (cur_cmd.trap == TRAP_IRQ);
               o_ctrl.e_op        = (cur_cmd.trap == TRAP_ECALL) ||
                                    (cur_cmd.trap == TRAP_EBREAK);
               o_ctrl.ebreak      = (cur_cmd.trap == TRAP_EBREAK);
               o_ctrl.misalign    = (cur_cmd.trap == TRAP_MISALIGN);
               o_ctrl.mem_cmd     = cur_cmd.store;
            end
            KIND_MRET: begin
               o_ctrl.mret    = 1'b1;
               o_ctrl.ram_sel = SEL_MEPC;
            end
            default: begin
            end
         endcase
      end
   end

endmodule

// File: src/csr_scratch_ram.sv
`timescale 1ns/10ps

module csr_scratch_ram (
   input  logic               i_clk,
   input  logic               i_reset,
   input  csr_pkg::csr_cnt_t  i_cnt,
   input  csr_pkg::csr_ctrl_t i_ctrl,
   input  logic               i_d,
   input  logic               i_csr_in,
   output logic               o_q
);
   import csr_pkg::*;

   csr_data_t mscratch;
   csr_data_t mtvec;
   csr_data_t mepc;
   logic      sel_q;

   always_comb begin
      case (i_ctrl.ram_sel)
         SEL_MSCRATCH: sel_q = mscratch[0];
         SEL_MTVEC:    sel_q = mtvec[0];
         SEL_MEPC:     sel_q = mepc[0];
         default:      sel_q = 1'b0;
      endcase
   end

   // quiet between passes so it can be or-ed onto the result
   assign o_q = i_cnt.en & sel_q;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         mscratch <= '0;
         mtvec    <= '0;
         mepc     <= '0;
      end else if (i_cnt.en) begin
         if (i_ctrl.trap_taken) begin
            // mtvec goes out unchanged, faulting pc comes in
            mtvec <= {mtvec[0], mtvec[CSR_W-1:1]};
            mepc  <= {i_d, mepc[CSR_W-1:1]};
         end else if (i_ctrl.mret) begin
            mepc <= {mepc[0], mepc[CSR_W-1:1]};
         end else begin
            case (i_ctrl.ram_sel)
               SEL_MSCRATCH: mscratch <= {i_csr_in, mscratch[CSR_W-1:1]};
               SEL_MTVEC:    mtvec    <= {i_csr_in, mtvec[CSR_W-1:1]};
               SEL_MEPC:     mepc     <= {i_csr_in, mepc[CSR_W-1:1]};
               default: begin
               end
            endcase
         end
      end
   end

endmodule

// File: src/csr_status_bits.sv
`timescale 1ns/10ps

module csr_status_bits (
   input  logic               i_clk,
   input  logic               i_reset,
   input  csr_pkg::csr_cnt_t  i_cnt,
   input  csr_pkg::csr_ctrl_t i_ctrl,
   input  logic               i_mtip,
   input  logic               i_d,
   input  logic               i_ram_q,
   output logic               o_csr_in,
   output logic               o_q,
   output logic               o_new_irq
);
   import csr_pkg::*;

   logic       mstatus_mie;
   logic       mstatus_mpie;
   logic       mie_mtie;
   logic       mstatus_rd;
   logic       mcause31;
   logic [3:0] mcause3_0;
   logic [3:0] trap_cause;

   logic mcause_q;
   logic stat_q;
   logic csr_out;
   logic csr_in;
   logic en_q;
   logic pass_start;
   logic timer_irq;
   logic timer_irq_q;
   logic new_irq_q;

   assign pass_start = i_cnt.en & ~en_q;

   // mcause only has bits 3:0 and 31
   assign mcause_q = i_cnt.cnt0to3 ? mcause3_0[0] :
                     i_cnt.done    ? mcause31     :
                                     1'b0;

   // mie lands on bit 3 through mstatus_rd, mpie is never shown
   assign stat_q = (i_ctrl.mstatus_en & mstatus_rd) |
                   (i_ctrl.mie_en & i_cnt.cnt7 & mie_mtie) |
                   (i_ctrl.mcause_en & i_cnt.en & mcause_q);

   assign csr_out = stat_q | i_ram_q;

   always_comb begin
      case (i_ctrl.src)
         SRC_EXT: csr_in = i_d;
         SRC_SET: csr_in = csr_out | i_d;
         SRC_CLR: csr_in = csr_out & ~i_d;
         default: csr_in = csr_out;
      endcase
   end

   // ecall 11, ebreak 3, misaligned load 4 / store 6
   always_comb begin
      if (i_ctrl.pending_irq) begin
         trap_cause = 4'd7;
      end else if (i_ctrl.e_op) begin
         trap_cause = {~i_ctrl.ebreak, 3'b011};
      end else if (i_ctrl.misalign) begin
         trap_cause = {2'b01, i_ctrl.mem_cmd, 1'b0};
      end else begin
         trap_cause = 4'd0;
      end
   end

   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;

   assign o_csr_in  = csr_in;
   assign o_q       = stat_q;
   assign o_new_irq = new_irq_q;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_mtie     <= 1'b0;
         mstatus_rd   <= 1'b0;
         mcause31     <= 1'b0;
         mcause3_0    <= 4'd0;
         en_q         <= 1'b0;
         timer_irq_q  <= 1'b0;
         new_irq_q    <= 1'b0;
      end else begin
         en_q        <= i_cnt.en;
         mstatus_rd  <= i_cnt.cnt2 & mstatus_mie;
         timer_irq_q <= timer_irq;
         new_irq_q   <= timer_irq & ~timer_irq_q;

         if (i_ctrl.mstatus_en & i_cnt.cnt3) begin
            mstatus_mie <= csr_in;
         end
         if (i_ctrl.mstatus_en & i_cnt.cnt7) begin
            mstatus_mpie <= csr_in;
         end
         if (i_ctrl.mie_en & i_cnt.cnt7) begin
            mie_mtie <= csr_in;
         end

         // trap and mret act once, on the first bit of the pass
         if (i_ctrl.mret & pass_start) begin
            mstatus_mie <= mstatus_mpie;
         end
         if (i_ctrl.trap_taken & pass_start) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mcause31     <= i_ctrl.pending_irq;
            mcause3_0    <= trap_cause;
         end

         if (i_ctrl.mcause_en & i_cnt.en) begin
            if (i_cnt.cnt0to3) begin
               mcause3_0 <= {csr_in, mcause3_0[3:1]};
            end
            if (i_cnt.done) begin
               mcause31 <= csr_in;
            end
         end
      end
   end

endmodule

// File: src/csr_bit_counter.sv
`timescale 1ns/10ps

module csr_bit_counter (
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_en,
   output csr_pkg::csr_cnt_t o_cnt
);
   import csr_pkg::*;

   localparam int POS_W = $clog2(CSR_W);

   logic [POS_W-1:0] pos;

   // free wrap after the last bit
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         pos <= '0;
      end else if (i_en) begin
         pos <= pos + 1'b1;
      end
   end

   // strobes only while a pass runs
   always_comb begin
      o_cnt.en      = i_en;
      o_cnt.cnt0to3 = i_en & (pos < POS_W'(4));
      o_cnt.cnt2    = i_en & (pos == POS_W'(2));
      o_cnt.cnt3    = i_en & (pos == POS_W'(3));
      o_cnt.cnt7    = i_en & (pos == POS_W'(7));
      o_cnt.done    = i_en & (pos == POS_W'(CSR_W - 1));
   end

endmodule

// File: src/csr_pkg.sv
package csr_pkg;

   localparam int CSR_W = 32;

   typedef logic [CSR_W-1:0] csr_data_t;
   typedef logic [2:0]       csr_sel_t;
   typedef logic [1:0]       csr_src_t;
   typedef logic [1:0]       cmd_kind_t;
   typedef logic [1:0]       trap_kind_t;

   // csr select codes
   localparam csr_sel_t SEL_MSTATUS  = 3'd0;
   localparam csr_sel_t SEL_MIE      = 3'd1;
   localparam csr_sel_t SEL_MCAUSE   = 3'd2;
   localparam csr_sel_t SEL_MSCRATCH = 3'd3;
   localparam csr_sel_t SEL_MTVEC    = 3'd4;
   localparam csr_sel_t SEL_MEPC     = 3'd5;

   // next-bit source for a csr access
   localparam csr_src_t SRC_CSR = 2'b00;
   localparam csr_src_t SRC_EXT = 2'b01;
   localparam csr_src_t SRC_SET = 2'b10;
   localparam csr_src_t SRC_CLR = 2'b11;

   localparam cmd_kind_t KIND_CSR  = 2'd0;
   localparam cmd_kind_t KIND_TRAP = 2'd1;
   localparam cmd_kind_t KIND_MRET = 2'd2;

   localparam trap_kind_t TRAP_IRQ      = 2'd0;
   localparam trap_kind_t TRAP_ECALL    = 2'd1;
   localparam trap_kind_t TRAP_EBREAK   = 2'd2;
   localparam trap_kind_t TRAP_MISALIGN = 2'd3;

   typedef struct packed {
      cmd_kind_t  kind;
      csr_sel_t   sel;
      csr_src_t   src;
      trap_kind_t trap;
      logic       store;
      csr_data_t  data;
   } csr_cmd_t;

   typedef struct packed {
      csr_data_t data;
   } csr_rsp_t;

   // strobes for one serial pass
   typedef struct packed {
      logic en;
      logic cnt0to3;
      logic cnt2;
      logic cnt3;
      logic cnt7;
      logic done;
   } csr_cnt_t;

   typedef struct packed {
      logic     mstatus_en;
      logic     mie_en;
      logic     mcause_en;
      csr_sel_t ram_sel;
      csr_src_t src;
      logic     mret;
      logic     trap_taken;
      logic     pending_irq;
      logic     e_op;
      logic     ebreak;
      logic     misalign;
      logic     mem_cmd;
   } csr_ctrl_t;

endpackage
